/* source/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Address split is tag | set | offset
`define DC_ADDR_BITS     16
`define DC_DATA_BITS     32
`define DC_OFFSET_BITS   3
`define DC_SET_BITS      3
`define DC_SETS          8
`define DC_WAY_BITS      2
`define DC_WAYS          4
`define DC_TAG_BITS      10

// Miss queue and load identification
`define DC_MQ_DEPTH      8
`define DC_MQ_BITS       3
`define DC_ID_BITS       6

// Tag 0 is never handed out by memory
`define DC_MEM_TAG_BITS  4

`endif

/* source/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD,
        MEM_DOUBLE
    } mem_size_t;

    typedef enum logic [1:0] {
        BUS_NONE,
        BUS_LOAD,
        BUS_STORE
    } bus_command_t;

    // One 8-byte block, indexed by byte, half or word
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
    } cache_line_t;

    typedef struct packed {
        logic [`DC_ADDR_BITS-1:0] address;
        mem_size_t                mem_size;
        logic                     load_signed;
        logic [`DC_ID_BITS-1:0]   id;
    } load_req_t;

    typedef struct packed {
        logic [`DC_ADDR_BITS-1:0] address;
        mem_size_t                mem_size;
        logic [`DC_DATA_BITS-1:0] data;
    } store_req_t;

    typedef struct packed {
        logic [`DC_ID_BITS-1:0]   id;
        logic [`DC_DATA_BITS-1:0] value;
    } load_result_t;

    typedef struct packed {
        bus_command_t             command;
        logic [`DC_ADDR_BITS-1:0] address;
        mem_size_t                size;
        logic [63:0]              data;
    } mem_req_t;

    typedef struct packed {
        logic [`DC_SET_BITS-1:0] set;
        logic [`DC_TAG_BITS-1:0] tag;
        cache_line_t             line;
    } fill_req_t;

    // Oldest miss, as seen by the result path
    typedef struct packed {
        cache_line_t              line;
        logic [`DC_ADDR_BITS-1:0] address;
        mem_size_t                mem_size;
        logic                     load_signed;
        logic [`DC_ID_BITS-1:0]   id;
    } mq_head_t;

endpackage

/* source/tree_plru.sv */
`include "dcache_cfg.svh"

module tree_plru (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [`DC_SET_BITS-1:0] lookup_set,
    input  logic                    load_update,
    input  logic [`DC_SET_BITS-1:0] load_set,
    input  logic [`DC_WAY_BITS-1:0] load_way,
    input  logic                    store_update,
    input  logic [`DC_SET_BITS-1:0] store_set,
    input  logic [`DC_WAY_BITS-1:0] store_way,
    output logic [`DC_WAY_BITS-1:0] plru_way
);

    // Bit 0 is the root, bit 1 covers ways 0/1, bit 2 covers ways 2/3
    logic [`DC_SETS-1:0][2:0] tree_bits;
    logic [2:0]               lookup_bits;

    logic                    touch;
    logic [`DC_SET_BITS-1:0] touch_set;
    logic [`DC_WAY_BITS-1:0] touch_way;

    assign lookup_bits = tree_bits[lookup_set];

    // Follow the bits toward the colder leaf
    assign plru_way = lookup_bits[0] ? {1'b1, lookup_bits[2]} : {1'b0, lookup_bits[1]};

    // Load touch wins over store touch
    always_comb begin
        touch     = load_update || store_update;
        touch_set = load_update ? load_set : store_set;
        touch_way = load_update ? load_way : store_way;
    end

    // Point every node on the path away from the touched way
    always_ff @(posedge clock) begin
        if (reset) begin
            tree_bits <= '0;
        end else if (touch) begin
            tree_bits[touch_set][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree_bits[touch_set][2] <= ~touch_way[0];
            end else begin
                tree_bits[touch_set][1] <= ~touch_way[0];
            end
        end
    end

endmodule

/* source/cache_array.sv */
`include "dcache_cfg.svh"

module cache_array import dcache_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     load_valid,
    input  logic [`DC_ADDR_BITS-1:0] load_address,
    output logic                     load_hit,
    output logic [`DC_WAY_BITS-1:0]  load_hit_way,
    output cache_line_t              hit_line,
    input  logic                     store_valid,
    input  store_req_t               store_req,
    output logic                     store_hit,
    output logic [`DC_WAY_BITS-1:0]  store_hit_way,
    input  logic                     fill_valid,
    input  fill_req_t                fill,
    input  logic [`DC_WAY_BITS-1:0]  plru_way,
    output logic [`DC_WAY_BITS-1:0]  fill_way
);

    localparam int TAG_LSB = `DC_OFFSET_BITS + `DC_SET_BITS;

    logic [`DC_SETS-1:0][`DC_WAYS-1:0] valid;
    logic [`DC_TAG_BITS-1:0]           tags [`DC_SETS][`DC_WAYS];
    cache_line_t                       lines [`DC_SETS][`DC_WAYS];

    logic [`DC_SET_BITS-1:0] load_set;
    logic [`DC_TAG_BITS-1:0] load_tag;
    logic [`DC_SET_BITS-1:0] store_set;
    logic [`DC_TAG_BITS-1:0] store_tag;
    logic                    store_blocked;
    cache_line_t             merged;

    assign load_set  = load_address[TAG_LSB-1:`DC_OFFSET_BITS];
    assign load_tag  = load_address[`DC_ADDR_BITS-1:TAG_LSB];
    assign store_set = store_req.address[TAG_LSB-1:`DC_OFFSET_BITS];
    assign store_tag = store_req.address[`DC_ADDR_BITS-1:TAG_LSB];

    // Compare all ways for both ports
    always_comb begin
        load_hit      = 1'b0;
        load_hit_way  = '0;
        store_hit     = 1'b0;
        store_hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (valid[load_set][w] && tags[load_set][w] == load_tag) begin
                load_hit     = load_valid;
                load_hit_way = `DC_WAY_BITS'(w);
            end
            if (valid[store_set][w] && tags[store_set][w] == store_tag) begin
                store_hit     = store_valid;
                store_hit_way = `DC_WAY_BITS'(w);
            end
        end
    end

    assign hit_line = lines[load_set][load_hit_way];

    // Lowest invalid way first, else PLRU
    always_comb begin
        fill_way = plru_way;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!valid[fill.set][w]) begin
                fill_way = `DC_WAY_BITS'(w);
            end
        end
    end

    // Fill overwrites the same slot, so the store only reaches memory
    assign store_blocked = fill_valid && fill.set == store_set && fill_way == store_hit_way;

    always_comb begin
        merged = lines[store_set][store_hit_way];
        case (store_req.mem_size)
            MEM_BYTE: merged.bytes[store_req.address[2:0]]  = store_req.data[7:0];
            MEM_HALF: merged.halves[store_req.address[2:1]] = store_req.data[15:0];
            default:  merged.words[store_req.address[2]]    = store_req.data;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (fill_valid) begin
            valid[fill.set][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid) begin
            tags[fill.set][fill_way]  <= fill.tag;
            lines[fill.set][fill_way] <= fill.line;
        end
        if (store_hit && !store_blocked) begin
            lines[store_set][store_hit_way] <= merged;
        end
    end

endmodule

/* source/miss_queue.sv */
`include "dcache_cfg.svh"

module miss_queue import dcache_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        load_accept,
    input  load_req_t                   load_req,
    output logic                        full,
    input  logic                        store_valid,
    input  store_req_t                  store_req,
    output mem_req_t                    mem_req,
    input  logic [`DC_MEM_TAG_BITS-1:0] mem_response,
    input  logic                        mem_data_valid,
    input  logic [`DC_MEM_TAG_BITS-1:0] mem_data_tag,
    input  cache_line_t                 mem_data,
    output logic                        head_done,
    output mq_head_t                    head,
    input  logic                        head_retire,
    output logic                        fill_valid,
    output fill_req_t                   fill
);

    localparam int TAG_LSB = `DC_OFFSET_BITS + `DC_SET_BITS;

    typedef struct packed {
        logic                        valid;
        logic                        done;
        logic                        alloc;
        logic [`DC_MEM_TAG_BITS-1:0] mem_tag;
        cache_line_t                 line;
        load_req_t                   req;
    } mq_entry_t;

    mq_entry_t              entries [`DC_MQ_DEPTH];
    logic [`DC_MQ_BITS-1:0] head_ptr;
    logic [`DC_MQ_BITS-1:0] send_ptr;
    logic [`DC_MQ_BITS-1:0] tail_ptr;

    mq_entry_t head_entry;
    mq_entry_t send_entry;
    logic      send_load;
    logic      issue;

    assign head_entry = entries[head_ptr];
    assign send_entry = entries[send_ptr];

    // Entries stay in order, so a live tail slot means no room
    assign full      = entries[tail_ptr].valid;
    // An issued entry already holds its nonzero memory tag
    assign send_load = send_entry.valid && !send_entry.done && send_entry.mem_tag == '0;

    // Stores take the bus first
    always_comb begin
        mem_req = '0;
        if (store_valid) begin
            mem_req.command = BUS_STORE;
            mem_req.address = store_req.address;
            mem_req.size    = store_req.mem_size;
            mem_req.data    = 64'(store_req.data);
        end else if (send_load) begin
            mem_req.command = BUS_LOAD;
            mem_req.address = {send_entry.req.address[`DC_ADDR_BITS-1:`DC_OFFSET_BITS],
                               {`DC_OFFSET_BITS{1'b0}}};
            mem_req.size    = MEM_DOUBLE;
        end
    end

    assign issue = mem_req.command == BUS_LOAD && mem_response != '0;

    assign head_done = head_entry.valid && head_entry.done;
    assign head = {head_entry.line, head_entry.req.address, head_entry.req.mem_size,
                   head_entry.req.load_signed, head_entry.req.id};

    assign fill_valid = head_retire && head_entry.alloc;
    assign fill = {head_entry.req.address[TAG_LSB-1:`DC_OFFSET_BITS],
                   head_entry.req.address[`DC_ADDR_BITS-1:TAG_LSB], head_entry.line};

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            send_ptr <= '0;
            tail_ptr <= '0;
            for (int i = 0; i < `DC_MQ_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].done  <= 1'b0;
            end
        end else begin
            // Returning block, matched by memory tag
            for (int i = 0; i < `DC_MQ_DEPTH; i++) begin
                if (mem_data_valid && entries[i].valid && !entries[i].done &&
                        entries[i].mem_tag != '0 && entries[i].mem_tag == mem_data_tag) begin
                    entries[i].done <= 1'b1;
                    entries[i].line <= mem_data;
                end
            end
            if (issue) begin
                entries[send_ptr].mem_tag <= mem_response;
                send_ptr                  <= send_ptr + 1'b1;
            end
            if (head_retire) begin
                // Done siblings of the same block see the retiring copy
                for (int i = 0; i < `DC_MQ_DEPTH; i++) begin
                    if (`DC_MQ_BITS'(i) != head_ptr && entries[i].valid && entries[i].done &&
                            entries[i].req.address[`DC_ADDR_BITS-1:`DC_OFFSET_BITS] ==
                            head_entry.req.address[`DC_ADDR_BITS-1:`DC_OFFSET_BITS]) begin
                        entries[i].line <= head_entry.line;
                    end
                end
                entries[head_ptr].valid <= 1'b0;
                entries[head_ptr].done  <= 1'b0;
                head_ptr                <= head_ptr + 1'b1;
            end
            if (load_accept) begin
                // Only the youngest miss to a block allocates
                for (int i = 0; i < `DC_MQ_DEPTH; i++) begin
                    if (entries[i].valid &&
                            entries[i].req.address[`DC_ADDR_BITS-1:`DC_OFFSET_BITS] ==
                            load_req.address[`DC_ADDR_BITS-1:`DC_OFFSET_BITS]) begin
                        entries[i].alloc <= 1'b0;
                    end
                end
                entries[tail_ptr].valid   <= 1'b1;
                entries[tail_ptr].done    <= 1'b0;
                // Block being filled right now is already covered
                entries[tail_ptr].alloc   <= !(fill_valid &&
                    head_entry.req.address[`DC_ADDR_BITS-1:`DC_OFFSET_BITS] ==
                    load_req.address[`DC_ADDR_BITS-1:`DC_OFFSET_BITS]);
                entries[tail_ptr].mem_tag <= '0;
                entries[tail_ptr].req     <= load_req;
                tail_ptr                  <= tail_ptr + 1'b1;
            end
        end
    end

endmodule

/* source/load_result.sv */
`include "dcache_cfg.svh"

module load_result import dcache_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         load_hit,
    input  load_req_t    load_req,
    input  cache_line_t  hit_line,
    input  logic         head_done,
    input  mq_head_t     head,
    output logic         head_retire,
    output logic         result_valid,
    output load_result_t result
);

    cache_line_t              line;
    logic [`DC_ADDR_BITS-1:0] address;
    mem_size_t                mem_size;
    logic                     load_signed;
    logic [`DC_ID_BITS-1:0]   id;
    logic [7:0]               pick_byte;
    logic [15:0]              pick_half;
    logic [`DC_DATA_BITS-1:0] value;

    // Head only goes when no hit claims the result register
    assign head_retire = head_done && !load_hit;

    always_comb begin
        if (load_hit) begin
            line        = hit_line;
            address     = load_req.address;
            mem_size    = load_req.mem_size;
            load_signed = load_req.load_signed;
            id          = load_req.id;
        end else begin
            line        = head.line;
            address     = head.address;
            mem_size    = head.mem_size;
            load_signed = head.load_signed;
            id          = head.id;
        end
    end

    assign pick_byte = line.bytes[address[2:0]];
    assign pick_half = line.halves[address[2:1]];

    // Sign or zero extend to the full value
    always_comb begin
        case (mem_size)
            MEM_BYTE: value = {{24{load_signed && pick_byte[7]}}, pick_byte};
            MEM_HALF: value = {{16{load_signed && pick_half[15]}}, pick_half};
            default:  value = line.words[address[2]];
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= load_hit || head_done;
        end
    end

    always_ff @(posedge clock) begin
        result.id    <= id;
        result.value <= value;
    end

endmodule

/* source/dcache.sv */
`include "dcache_cfg.svh"

module dcache import dcache_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        load_valid,
    input  load_req_t                   load_req,
    output logic                        load_ready,
    input  logic                        store_valid,
    input  store_req_t                  store_req,
    output mem_req_t                    mem_req,
    input  logic [`DC_MEM_TAG_BITS-1:0] mem_response,
    input  logic                        mem_data_valid,
    input  logic [`DC_MEM_TAG_BITS-1:0] mem_data_tag,
    input  cache_line_t                 mem_data,
    output logic                        result_valid,
    output load_result_t                result
);

    localparam int TAG_LSB = `DC_OFFSET_BITS + `DC_SET_BITS;

    logic                    load_accept;
    logic                    load_miss;
    logic                    mq_full;
    logic                    load_hit;
    logic [`DC_WAY_BITS-1:0] load_hit_way;
    cache_line_t             hit_line;
    logic                    store_hit;
    logic [`DC_WAY_BITS-1:0] store_hit_way;
    logic                    fill_valid;
    fill_req_t               fill;
    logic [`DC_WAY_BITS-1:0] fill_way;
    logic [`DC_WAY_BITS-1:0] plru_way;
    logic                    head_done;
    mq_head_t                head;
    logic                    head_retire;
    logic                    plru_load_update;
    logic [`DC_SET_BITS-1:0] plru_load_set;
    logic [`DC_WAY_BITS-1:0] plru_load_way;

    assign load_ready  = !mq_full;
    assign load_accept = load_valid && load_ready;
    assign load_miss   = load_accept && !load_hit;

    // A hit and a fill never share a cycle
    assign plru_load_update = load_hit || fill_valid;
    assign plru_load_set    = load_hit ? load_req.address[TAG_LSB-1:`DC_OFFSET_BITS] : fill.set;
    assign plru_load_way    = load_hit ? load_hit_way : fill_way;

    tree_plru tree_plru_inst (
        .clock        (clock),
        .reset        (reset),
        .lookup_set   (fill.set),
        .load_update  (plru_load_update),
        .load_set     (plru_load_set),
        .load_way     (plru_load_way),
        .store_update (store_hit),
        .store_set    (store_req.address[TAG_LSB-1:`DC_OFFSET_BITS]),
        .store_way    (store_hit_way),
        .plru_way     (plru_way)
    );

    cache_array cache_array_inst (
        .clock         (clock),
        .reset         (reset),
        .load_valid    (load_accept),
        .load_address  (load_req.address),
        .load_hit      (load_hit),
        .load_hit_way  (load_hit_way),
        .hit_line      (hit_line),
        .store_valid   (store_valid),
        .store_req     (store_req),
        .store_hit     (store_hit),
        .store_hit_way (store_hit_way),
        .fill_valid    (fill_valid),
        .fill          (fill),
        .plru_way      (plru_way),
        .fill_way      (fill_way)
    );

    miss_queue miss_queue_inst (
        .clock          (clock),
        .reset          (reset),
        .load_accept    (load_miss),
        .load_req       (load_req),
        .full           (mq_full),
        .store_valid    (store_valid),
        .store_req      (store_req),
        .mem_req        (mem_req),
        .mem_response   (mem_response),
        .mem_data_valid (mem_data_valid),
        .mem_data_tag   (mem_data_tag),
        .mem_data       (mem_data),
        .head_done      (head_done),
        .head           (head),
        .head_retire    (head_retire),
        .fill_valid     (fill_valid),
        .fill           (fill)
    );

    load_result load_result_inst (
        .clock        (clock),
        .reset        (reset),
        .load_hit     (load_hit),
        .load_req     (load_req),
        .hit_line     (hit_line),
        .head_done    (head_done),
        .head         (head),
        .head_retire  (head_retire),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

/* dv/dcache_tb.sv */
`include "dcache_cfg.svh"

module dcache_tb import dcache_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_RECORDS = 128;
    localparam int FIELDS      = 7;
    localparam int OP_IDLE     = 0;
    localparam int OP_LOAD     = 1;
    localparam int OP_STORE    = 2;
    localparam int OP_HIT      = 3;
    localparam int OP_HOLD     = 4;
    localparam int OP_FULL     = 5;

    logic         clock = 1'b0;
    logic         reset;
    logic         load_valid;
    load_req_t    load_req;
    logic         load_ready;
    logic         store_valid;
    store_req_t   store_req;
    mem_req_t     mem_req;
    logic [`DC_MEM_TAG_BITS-1:0] mem_response = 4'd1;
    logic         mem_data_valid = 1'b0;
    logic [`DC_MEM_TAG_BITS-1:0] mem_data_tag = '0;
    cache_line_t  mem_data = '0;
    logic         result_valid;
    load_result_t result;

    logic [31:0] stim [MAX_RECORDS*FIELDS];
    logic [7:0]  memory [65536];
    logic [31:0] expected_value [64];
    int          expected_test [64];
    bit          expected_open [64];
    int          record_count = 0;
    bit          stim_loaded = 1'b0;
    int          issued = 0;
    int          received = 0;
    int          cycle = 0;
    bit          hold_data = 1'b0;
    bit          load_taken = 1'b0;
    logic [31:0] rng_state = 32'd50;

    // Outstanding block reads in the memory model
    logic [`DC_MEM_TAG_BITS-1:0] pend_tag [$];
    logic [15:0]                 pend_addr [$];
    int                          pend_due [$];

    dcache dcache_inst (
        .clock          (clock),
        .reset          (reset),
        .load_valid     (load_valid),
        .load_req       (load_req),
        .load_ready     (load_ready),
        .store_valid    (store_valid),
        .store_req      (store_req),
        .mem_req        (mem_req),
        .mem_response   (mem_response),
        .mem_data_valid (mem_data_valid),
        .mem_data_tag   (mem_data_tag),
        .mem_data       (mem_data),
        .result_valid   (result_valid),
        .result         (result)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Data returns at the falling edge and the bus is sampled late in the cycle
    always @(negedge clock) begin
        int pick;
        int lat;
        pick = -1;
        mem_data_valid = 1'b0;
        if (load_taken) begin
            mem_response = (mem_response == 4'd15) ? 4'd1 : mem_response + 4'd1;
            load_taken = 1'b0;
        end
        if (!hold_data) begin
            for (int i = 0; i < pend_tag.size(); i++) begin
                if (pick < 0 && pend_due[i] <= cycle) begin
                    pick = i;
                end
            end
        end
        if (pick >= 0) begin
            mem_data_valid = 1'b1;
            mem_data_tag = pend_tag[pick];
            for (int b = 0; b < 8; b++) begin
                mem_data.bytes[b] = memory[int'(pend_addr[pick]) + b];
            end
            pend_tag.delete(pick);
            pend_addr.delete(pick);
            pend_due.delete(pick);
        end
        #40;
        if (!reset && mem_req.command == BUS_LOAD) begin
            rng_state = xorshift(rng_state);
            lat = 2 + int'(rng_state % 5);
            pend_tag.push_back(mem_response);
            pend_addr.push_back(mem_req.address);
            pend_due.push_back(cycle + 1 + lat);
            load_taken = 1'b1;
        end else if (!reset && mem_req.command == BUS_STORE) begin
            for (int b = 0; b < (1 << mem_req.size); b++) begin
                memory[int'(mem_req.address) + b] = mem_req.data[8*b +: 8];
            end
        end
    end

    // Results checked by id
    always @(negedge clock) begin
        if (!reset && result_valid) begin
            if (!expected_open[result.id]) begin
                $display("A result arrived for load id %0d, which has no load outstanding",
                         result.id);
                $display("ERRORS FOUND");
                $fatal(1, "unexpected result id");
            end else begin
                compare_value($sformatf("behavior %0d load id %0d", expected_test[result.id],
                              result.id), expected_value[result.id], result.value);
                expected_open[result.id] = 1'b0;
                received = received + 1;
            end
        end
    end

    initial begin
        wait (stim_loaded);
        repeat (record_count * 40 + 8) @(posedge clock);
        $display("Timeout: load results never arrived, %0d of %0d received", received, issued);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int base;
        int test;
        int op;
        logic [31:0] arg;
        reset = 1'b1;
        load_valid = 1'b0;
        load_req = '0;
        store_valid = 1'b0;
        store_req = '0;
        for (int i = 0; i < MAX_RECORDS * FIELDS; i++) begin
            stim[i] = 32'hffff_ffff;
        end
        for (int a = 0; a < 65536; a++) begin
            memory[a] = a[7:0] ^ 8'h5a;
        end
        $readmemh("dv/dcache_stim.txt", stim);
        while (record_count < MAX_RECORDS && stim[record_count*FIELDS] !== 32'hffff_ffff) begin
            record_count = record_count + 1;
        end
        stim_loaded = 1'b1;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int r = 0; r < record_count; r++) begin
            base = r * FIELDS;
            test = int'(stim[base]);
            op   = int'(stim[base+1]);
            arg  = stim[base+5];
            // A hit needs every earlier miss filled
            if (op == OP_HIT) begin
                while (received != issued) @(negedge clock);
            end
            if (op == OP_LOAD || op == OP_HIT) begin
                while (!load_ready) @(negedge clock);
            end
            case (op)
                OP_LOAD, OP_HIT: begin
                    load_valid = 1'b1;
                    load_req.address = stim[base+2][15:0];
                    load_req.mem_size = mem_size_t'(stim[base+3][1:0]);
                    load_req.load_signed = stim[base+4][0];
                    load_req.id = arg[5:0];
                    expected_value[arg[5:0]] = stim[base+6];
                    expected_test[arg[5:0]] = test;
                    expected_open[arg[5:0]] = 1'b1;
                    issued = issued + 1;
                end
                OP_STORE: begin
                    store_valid = 1'b1;
                    store_req.address = stim[base+2][15:0];
                    store_req.mem_size = mem_size_t'(stim[base+3][1:0]);
                    store_req.data = arg;
                end
                OP_HOLD: hold_data = arg[0];
                OP_FULL: compare_value($sformatf("behavior %0d load_ready", test),
                                       32'd0, {31'd0, load_ready});
                OP_IDLE: ;
                default: ;
            endcase
            @(negedge clock);
            load_valid = 1'b0;
            store_valid = 1'b0;
            if (op == OP_HIT) begin
                compare_value($sformatf("behavior %0d hit result_valid", test),
                              32'd1, {31'd0, result_valid});
                compare_value($sformatf("behavior %0d hit result id", test),
                              arg, {26'd0, result.id});
            end
        end
        while (received != issued) @(negedge clock);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* dcache.f */
+incdir+source
source/dcache_pkg.sv
source/tree_plru.sv
source/cache_array.sv
source/miss_queue.sv
source/load_result.sv
source/dcache.sv
dv/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - source
    files:
      - source/dcache_pkg.sv
      - source/tree_plru.sv
      - source/cache_array.sv
      - source/miss_queue.sv
      - source/load_result.sv
      - source/dcache.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/dcache_tb.sv

/* dv/dcache_stim.txt */
// behavior op address size signed data_or_id expected (all hex)
// op 0 idle, 1 load, 2 store, 3 load that must hit, 4 hold memory data, 5 load_ready low
1 1 0010 2 0 01 49484B4A
1 3 0014 2 0 02 4D4C4F4E
2 1 0088 0 1 03 FFFFFFD2
2 1 0089 0 0 04 000000D3
2 1 008A 0 1 05 FFFFFFD0
2 1 008B 0 0 06 000000D1
2 1 008C 0 1 07 FFFFFFD6
2 1 008D 0 0 08 000000D7
2 1 008E 0 1 09 FFFFFFD4
2 1 008F 0 0 0A 000000D5
2 1 0088 1 1 0B FFFFD3D2
2 1 008A 1 0 0C 0000D1D0
2 1 008C 1 1 0D FFFFD7D6
2 1 008E 1 0 0E 0000D5D4
2 1 0088 2 0 0F D1D0D3D2
2 1 008C 2 1 10 D5D4D7D6
2 1 0011 0 1 11 0000004B
2 1 0012 1 1 12 00004948
3 3 0088 2 0 13 D1D0D3D2
3 2 0088 2 0 12345678 0
3 2 008D 0 0 000000AB 0
3 3 0088 2 0 14 12345678
3 3 008D 0 1 15 FFFFFFAB
3 3 008C 1 0 16 0000ABD6
3 2 0302 1 0 0000BEEF 0
3 1 0300 2 0 17 BEEF5B5A
3 1 0304 2 0 18 5D5C5F5E
4 3 0300 2 0 19 BEEF5B5A
4 4 0000 0 0 1 0
4 1 0400 2 0 1A 59585B5A
4 1 0408 2 0 1B 51505352
4 1 0401 0 0 1C 0000005B
4 1 0410 2 0 1D 49484B4A
4 1 0406 1 1 1E 00005D5C
4 1 0418 2 0 1F 41404342
4 1 040C 2 0 20 55545756
4 1 0420 2 0 21 79787B7A
4 5 0000 0 0 0 0
4 4 0000 0 0 0 0
4 1 0404 2 0 22 5D5C5F5E
4 0 0000 0 0 0 0
5 1 0100 2 0 23 59585B5A
5 1 0140 2 0 24 19181B1A
5 1 0180 2 0 25 D9D8DBDA
5 1 01C0 2 0 26 99989B9A
5 1 0200 2 0 27 59585B5A
5 1 0104 2 0 28 5D5C5F5E
5 1 0144 2 0 29 1D1C1F1E
5 1 0204 2 0 2A 5D5C5F5E
5 1 0181 0 1 2B FFFFFFDB
5 1 01C4 2 0 2C 9D9C9F9E
5 1 0102 1 0 2D 00005958
5 1 0300 2 0 2E BEEF5B5A
